//--- sources.f
source/cmd_decoder_pkg.sv
source/char_credit_queue.sv
source/nibble_counter.sv
source/hex_word_packer.sv
source/cmd_parser_fsm.sv
source/cmd_decoder_top.sv
verification/cmd_decoder_tb.sv

//--- verification/cmd_decoder_testdata.txt
# C <text>: send the text, then a newline
# E <kind> <a> <b>: expected event, hex; kinds 1 halt 2 start 3 step 4 cycle 5 rst (a = freeze)
#   6 program write (a = address, b = data), 7 page change (a = dv_page, b = pv_page)

# plain commands
C H
E 1 0 0
C Z
E 2 0 0
C S1
E 3 0 0
C S>
E 4 0 0
C R
E 5 0 0

# view pages
C V000000A5,00001234
E 7 a5 34

# program load of three words
C [11223344,a5a5a5a5,DEADbeef]
E 1 1 0
E 6 0 11223344
E 6 4 a5a5a5a5
E 6 8 deadbeef
E 5 0 0

# broken lines are dropped, the next line decodes
C Q
C H
E 1 0 0
C V0000g000,00000001
C Z
E 2 0 0
C V1234,00000001
C S1
E 3 0 0
C S2
C V00000001,0002
C V00000102,0000FF07
E 7 02 07
C R
E 5 0 0

//--- verification/cmd_decoder_tb.sv
`timescale 1ns/1ps

module cmd_decoder_tb
    import cmd_decoder_pkg::*;
;

    logic                      clk;
    logic                      n_rst;
    logic                      char_valid;
    logic [7:0]                char_in;
    logic                      credit_return;
    logic                      cpu_halt, cpu_start, cpu_step, cpu_cycle, cpu_rst;
    logic                      freeze;
    logic [DV_PAGE_BITS-1:0]   dv_page;
    logic [PV_PAGE_BITS-1:0]   pv_page;
    logic                      prog_en;
    logic [PROG_ADDR_BITS-1:0] prog_addr;
    logic [WORD_BITS-1:0]      prog_data;

    logic [7:0]  char_q [$];        // every character to send, newlines included
    logic [31:0] exp_kind [$], exp_a [$], exp_b [$];
    logic [31:0] ev_kind [$], ev_a [$], ev_b [$];
    logic [15:0] last_pages = '0;
    int          seed = 90;
    int          sent = 0;
    int          returned = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    cmd_decoder_top DUT (.*);

    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t ns: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic log_event(input logic [31:0] kind, input logic [31:0] a,
                             input logic [31:0] b);
        ev_kind.push_back(kind);
        ev_a.push_back(a);
        ev_b.push_back(b);
    endtask

    task automatic read_testdata();
        int          fd;
        int          n;
        int          i;
        string       line;
        string       tag;
        string       text;
        logic [31:0] k, a, b;
        fd = $fopen("verification/cmd_decoder_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open the test data file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%s", tag);
            if (n != 1) continue;           // blank line
            if (tag == "C") begin
                n = $sscanf(line, "%s %s", tag, text);
                for (i = 0; i < text.len(); i++) begin
                    char_q.push_back(text[i]);
                end
                char_q.push_back(8'h0a);    // each C line is one command line
            end else if (tag == "E") begin
                n = $sscanf(line, "%s %h %h %h", tag, k, a, b);
                if (n != 4) stop_with_error("a line of expected values is incomplete");
                exp_kind.push_back(k);
                exp_a.push_back(a);
                exp_b.push_back(b);
            end else begin
                stop_with_error("the test data file holds a line of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    task automatic send_char(input logic [7:0] c);
        int gap;
        gap = {$random(seed)} % 4;
        repeat (gap) begin
            @(posedge clk);
            char_valid <= 1'b0;
        end
        // hold off while no credit is left
        while (CHAR_FIFO_DEPTH - sent + returned <= 0) begin
            @(posedge clk);
            char_valid <= 1'b0;
        end
        @(posedge clk);
        char_valid <= 1'b1;
        char_in    <= c;
        sent++;
    endtask

    task automatic check_reset_state();
        check_value("pulses after reset",
                    {cpu_halt, cpu_start, cpu_step, cpu_cycle, cpu_rst, prog_en}, '0);
        check_value("freeze after reset", freeze, 0);
        check_value("credit_return after reset", credit_return, 0);
        check_value("char_avail after reset", DUT.u_queue.char_avail, 0);
        check_value("pages after reset", {dv_page, pv_page}, 0);
        check_value("prog_addr after reset", prog_addr, 0);
        check_value("parser state after reset", DUT.u_parser.state, wait_cmd);
    endtask

    task automatic compare_events();
        int i;
        for (i = 0; i < exp_kind.size(); i++) begin
            if (i >= ev_kind.size()) begin
                stop_with_error($sformatf("expected event %0d never appeared", i));
            end
            check_value($sformatf("event %0d kind", i), ev_kind[i], exp_kind[i]);
            check_value($sformatf("event %0d first value", i), ev_a[i], exp_a[i]);
            check_value($sformatf("event %0d second value", i), ev_b[i], exp_b[i]);
        end
        if (ev_kind.size() > exp_kind.size()) begin
            stop_with_error("the DUT produced more events than the test data expects");
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (n_rst) begin
            if (cpu_halt)  log_event(1, freeze, 0);
            if (cpu_start) log_event(2, freeze, 0);
            if (cpu_step)  log_event(3, freeze, 0);
            if (cpu_cycle) log_event(4, freeze, 0);
            if (cpu_rst)   log_event(5, freeze, 0);
            if (prog_en)   log_event(6, prog_addr, prog_data);
            if ({dv_page, pv_page} != last_pages) begin
                log_event(7, dv_page, pv_page);
                last_pages = {dv_page, pv_page};
            end
            if (credit_return) returned++;
            if (returned > sent) begin
                stop_with_error("a credit came back for a character never sent");
            end
            if (DUT.u_queue.fill > CHAR_FIFO_DEPTH) begin
                stop_with_error("the character queue holds more characters than its depth");
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            stop_with_error("timeout, the DUT did not finish in time");
        end
    end

    initial begin
        clk        = 1'b0;
        n_rst      = 1'b0;
        char_valid = 1'b0;
        char_in    = '0;
        read_testdata();
        cycle_limit = char_q.size() * 8 + 200;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        check_reset_state();
        foreach (char_q[i]) send_char(char_q[i]);
        @(posedge clk);
        char_valid <= 1'b0;
        wait (returned == sent);    // last credit comes with the last pulse
        @(negedge clk);
        compare_events();
        check_value("queue fill once every credit is back", DUT.u_queue.fill, 0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- source/cmd_decoder_top.sv
`timescale 1ns/1ps

module cmd_decoder_top
    import cmd_decoder_pkg::*;
(
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      char_valid,
    input  logic [7:0]                char_in,
    output logic                      credit_return,
    output logic                      cpu_halt,
    output logic                      cpu_start,
    output logic                      cpu_step,
    output logic                      cpu_cycle,
    output logic                      cpu_rst,
    output logic                      freeze,
    output logic [DV_PAGE_BITS-1:0]   dv_page,
    output logic [PV_PAGE_BITS-1:0]   pv_page,
    output logic                      prog_en,
    output logic [PROG_ADDR_BITS-1:0] prog_addr,
    output logic [WORD_BITS-1:0]      prog_data
);

    logic                 char_avail;
    logic                 char_take;
    logic [7:0]           q_char;     // head of the queue
    logic                 nib_push;
    logic                 nib_clear;
    logic                 word_clear;
    logic                 word_full;
    logic                 not_hex;
    logic [WORD_BITS-1:0] word;

    char_credit_queue u_queue (
        .clk           (clk),
        .n_rst         (n_rst),
        .char_valid    (char_valid),
        .char_in       (char_in),
        .char_take     (char_take),
        .char_avail    (char_avail),
        .char_out      (q_char),
        .credit_return (credit_return)
    );

    cmd_parser_fsm u_parser (
        .clk        (clk),
        .n_rst      (n_rst),
        .char_avail (char_avail),
        .char_in    (q_char),
        .not_hex    (not_hex),
        .word_full  (word_full),
        .word       (word),
        .char_take  (char_take),
        .nib_push   (nib_push),
        .nib_clear  (nib_clear),
        .word_clear (word_clear),
        .cpu_halt   (cpu_halt),
        .cpu_start  (cpu_start),
        .cpu_step   (cpu_step),
        .cpu_cycle  (cpu_cycle),
        .cpu_rst    (cpu_rst),
        .freeze     (freeze),
        .dv_page    (dv_page),
        .pv_page    (pv_page),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

    nibble_counter u_nib_cnt (
        .clk       (clk),
        .n_rst     (n_rst),
        .nib_push  (nib_push),
        .nib_clear (nib_clear),
        .word_full (word_full)
    );

    // decodes the queue head directly, same char the parser sees
    hex_word_packer u_packer (
        .clk        (clk),
        .n_rst      (n_rst),
        .hex_char   (q_char),
        .nib_push   (nib_push),
        .word_clear (word_clear),
        .not_hex    (not_hex),
        .word       (word)
    );

endmodule

//--- source/cmd_parser_fsm.sv
`timescale 1ns/1ps

module cmd_parser_fsm
    import cmd_decoder_pkg::*;
(
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      char_avail,
    input  logic [7:0]                char_in,
    input  logic                      not_hex,
    input  logic                      word_full,
    input  logic [WORD_BITS-1:0]      word,
    output logic                      char_take,
    output logic                      nib_push,
    output logic                      nib_clear,
    output logic                      word_clear,
    output logic                      cpu_halt,
    output logic                      cpu_start,
    output logic                      cpu_step,
    output logic                      cpu_cycle,
    output logic                      cpu_rst,
    output logic                      freeze,
    output logic [DV_PAGE_BITS-1:0]   dv_page,
    output logic [PV_PAGE_BITS-1:0]   pv_page,
    output logic                      prog_en,
    output logic [PROG_ADDR_BITS-1:0] prog_addr,
    output logic [WORD_BITS-1:0]      prog_data
);

    parse_state_t state, state_eff, state_nxt;
    cmd_t         cmd, cmd_nxt;

    logic                    is_nl;
    logic                    clr;         // restart digit count and word
    logic                    bad;
    logic                    line_abort;
    logic                    halt_set, start_set, step_set, cycle_set, rst_set;
    logic                    prog_start, load_done;
    logic                    write_word, latch_arg0, set_pages;
    logic                    step_cycle;  // S> rather than S1
    logic [DV_PAGE_BITS-1:0] dv_arg;

    assign is_nl      = (char_in == "\n");
    assign char_take  = char_avail;       // never stalls the queue
    assign nib_clear  = clr;
    assign word_clear = clr;

    always_comb begin
        cmd_nxt    = cmd;
        clr        = 1'b0;
        nib_push   = 1'b0;
        bad        = 1'b0;
        line_abort = 1'b0;
        halt_set   = 1'b0;
        start_set  = 1'b0;
        step_set   = 1'b0;
        cycle_set  = 1'b0;
        rst_set    = 1'b0;
        prog_start = 1'b0;
        load_done  = 1'b0;
        write_word = 1'b0;
        latch_arg0 = 1'b0;
        set_pages  = 1'b0;

        // a full word turns a digit state into its separator state
        if (state == read_arg0 && word_full) begin
            state_eff = arg_comma;
        end else if (state == prog_word && word_full) begin
            state_eff = prog_sep;
        end else begin
            state_eff = state;
        end
        state_nxt = state_eff;

        if (char_avail) begin
            case (state_eff)
                wait_cmd: begin
                    clr     = 1'b1;
                    cmd_nxt = cmd_none;
                    case (char_in)
                        "H":  state_nxt = end_halt;
                        "Z":  state_nxt = end_start;
                        "S":  state_nxt = read_step;
                        "R":  state_nxt = end_reset;
                        "V": begin
                            cmd_nxt   = cmd_view;
                            state_nxt = read_arg0;
                        end
                        "[": begin
                            cmd_nxt    = cmd_prog;
                            prog_start = 1'b1;
                            state_nxt  = prog_word;
                        end
                        "\n": state_nxt = wait_cmd;   // empty line
                        default: bad = 1'b1;
                    endcase
                end
                read_step: begin
                    if (char_in == "1" || char_in == ">") begin
                        state_nxt = end_step;
                    end else begin
                        bad = 1'b1;
                    end
                end
                end_halt, end_start, end_step, end_reset: begin
                    if (is_nl) begin
                        halt_set  = (state_eff == end_halt);
                        start_set = (state_eff == end_start);
                        step_set  = (state_eff == end_step) && !step_cycle;
                        cycle_set = (state_eff == end_step) && step_cycle;
                        rst_set   = (state_eff == end_reset);
                        state_nxt = wait_cmd;
                    end else begin
                        bad = 1'b1;
                    end
                end
                read_arg0, prog_word: begin
                    if (!not_hex) begin
                        nib_push = 1'b1;
                    end else begin
                        bad = 1'b1;       // also covers an early separator
                    end
                end
                arg_comma: begin
                    if (char_in == ",") begin
                        latch_arg0 = 1'b1;
                        clr        = 1'b1;
                        state_nxt  = read_arg1;
                    end else begin
                        bad = 1'b1;
                    end
                end
                read_arg1: begin
                    if (word_full) begin
                        if (is_nl) begin
                            set_pages = 1'b1;
                            state_nxt = wait_cmd;
                        end else begin
                            bad = 1'b1;
                        end
                    end else if (!not_hex) begin
                        nib_push = 1'b1;
                    end else begin
                        bad = 1'b1;
                    end
                end
                prog_sep: begin
                    if (char_in == "," || char_in == "]") begin
                        write_word = 1'b1;
                        clr        = 1'b1;
                        state_nxt  = (char_in == "]") ? end_prog : prog_word;
                    end else begin
                        bad = 1'b1;
                    end
                end
                end_prog: begin
                    if (is_nl) begin
                        load_done = 1'b1;
                        state_nxt = wait_cmd;
                    end else begin
                        bad = 1'b1;
                    end
                end
                default: bad = 1'b1;  // bad_cmd keeps discarding
            endcase

            // a newline always ends the line, even a broken one
            if (bad) begin
                if (is_nl) begin
                    line_abort = 1'b1;
                end else begin
                    state_nxt = bad_cmd;
                end
            end
            if (line_abort) begin
                state_nxt = wait_cmd;
                load_done = (cmd == cmd_prog);  // unfreeze an aborted load
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state     <= wait_cmd;
            cmd       <= cmd_none;
            cpu_halt  <= 1'b0;
            cpu_start <= 1'b0;
            cpu_step  <= 1'b0;
            cpu_cycle <= 1'b0;
            cpu_rst   <= 1'b0;
            prog_en   <= 1'b0;
            freeze    <= 1'b0;
            dv_page   <= '0;
            pv_page   <= '0;
            prog_addr <= '0;
        end else begin
            state     <= state_nxt;
            cmd       <= cmd_nxt;
            cpu_halt  <= halt_set || prog_start;
            cpu_start <= start_set;
            cpu_step  <= step_set;
            cpu_cycle <= cycle_set;
            cpu_rst   <= rst_set || load_done;
            prog_en   <= write_word;

            if (prog_start) begin
                freeze <= 1'b1;
            end else if (load_done) begin
                freeze <= 1'b0;
            end

            // address holds during the write pulse, steps right after
            if (prog_start) begin
                prog_addr <= '0;
            end else if (prog_en) begin
                prog_addr <= prog_addr + PROG_ADDR_BITS'(PROG_ADDR_STEP);
            end

            if (set_pages) begin
                dv_page <= dv_arg;
                pv_page <= word[PV_PAGE_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch_arg0) begin
            dv_arg <= word[DV_PAGE_BITS-1:0];
        end
        if (write_word) begin
            prog_data <= word;
        end
        if (char_avail && state == read_step) begin
            step_cycle <= (char_in == ">");
        end
    end

endmodule

//--- source/hex_word_packer.sv
`timescale 1ns/1ps

module hex_word_packer
    import cmd_decoder_pkg::*;
(
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic [7:0]           hex_char,
    input  logic                 nib_push,
    input  logic                 word_clear,
    output logic                 not_hex,
    output logic [WORD_BITS-1:0] word
);

    logic [3:0] nibble;

    // ascii hex decode
    // letters in both cases have low nibble 1..6, so +9 gives 10..15
    always_comb begin
        nibble  = '0;
        not_hex = 1'b0;
        if (hex_char >= "0" && hex_char <= "9") begin
            nibble = hex_char[3:0];
        end else if ((hex_char >= "a" && hex_char <= "f") ||
                     (hex_char >= "A" && hex_char <= "F")) begin
            nibble = hex_char[3:0] + 4'd9;
        end else begin
            not_hex = 1'b1;
        end
    end

    // most significant digit arrives first, so shift in at the bottom
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            word <= '0;
        end else if (word_clear) begin
            word <= '0;
        end else if (nib_push) begin
            word <= {word[WORD_BITS-5:0], nibble};
        end
    end

endmodule

//--- source/nibble_counter.sv
`timescale 1ns/1ps

module nibble_counter
    import cmd_decoder_pkg::*;
(
    input  logic clk,
    input  logic n_rst,
    input  logic nib_push,
    input  logic nib_clear,
    output logic word_full
);

    logic [NIB_CNT_BITS-1:0] nib_cnt;

    assign word_full = (nib_cnt == NIB_CNT_BITS'(WORD_NIBBLES));

    // clear wins over push, count sticks at a full word
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            nib_cnt <= '0;
        end else if (nib_clear) begin
            nib_cnt <= '0;
        end else if (nib_push && !word_full) begin
            nib_cnt <= nib_cnt + 1'b1;
        end
    end

endmodule

//--- source/char_credit_queue.sv
`timescale 1ns/1ps

module char_credit_queue
    import cmd_decoder_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       char_valid,
    input  logic [7:0] char_in,
    input  logic       char_take,
    output logic       char_avail,
    output logic [7:0] char_out,
    output logic       credit_return
);

    logic [7:0]               mem [CHAR_FIFO_DEPTH];
    logic [CHAR_PTR_BITS-1:0] wr_ptr;
    logic [CHAR_PTR_BITS-1:0] rd_ptr;
    logic [CHAR_PTR_BITS:0]   fill;
    logic                     pop;

    // sender holds credits, so a push never finds the buffer full
    assign pop        = char_take && char_avail;
    assign char_avail = (fill != '0);
    assign char_out   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (char_valid) begin
            mem[wr_ptr] <= char_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;   // one credit back per char popped
            if (char_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({char_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;      // idle, or push and pop together
            endcase
        end
    end

endmodule

//--- source/cmd_decoder_pkg.sv
package cmd_decoder_pkg;

    // character queue, also the credit count the sender starts with
    localparam int CHAR_FIFO_DEPTH = 4;       // power of two, pointers wrap freely
    localparam int CHAR_PTR_BITS   = $clog2(CHAR_FIFO_DEPTH);

    // hex words
    localparam int WORD_NIBBLES = 8;
    localparam int WORD_BITS    = WORD_NIBBLES * 4;
    localparam int NIB_CNT_BITS = $clog2(WORD_NIBBLES + 1);  // counts 0..WORD_NIBBLES

    // view pages
    localparam int DV_PAGE_BITS = 8;
    localparam int PV_PAGE_BITS = 8;

    // program write port
    localparam int PROG_ADDR_BITS = 20;
    localparam int PROG_ADDR_STEP = 4;        // byte address step per word

    typedef enum logic [3:0] {
        wait_cmd,
        read_arg0,
        arg_comma,
        read_arg1,
        read_step,
        end_halt,
        end_start,
        end_step,
        end_reset,
        prog_word,
        prog_sep,
        end_prog,
        bad_cmd
    } parse_state_t;

    // what the current line is building
    typedef enum logic [1:0] {
        cmd_none,
        cmd_view,
        cmd_prog
    } cmd_t;

endpackage
